// ==== Bender.yml ====
package:
  name: retire_core

dependencies: {}

sources:
  - files:
      - hw/retire_pkg.sv
      - hw/reorder_buffer.sv
      - hw/rename_table.sv
      - hw/arch_regfile.sv
      - hw/retire_core.sv
  - target: test
    files:
      - bench/retire_core_tb.sv

// ==== bench/retire_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_core_tb import retire_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int SEED = 32'h8d88;
	// rough cycle count of all tests together, and the slack on top of it
	localparam int TEST_CYCLES = 320;
	localparam int WATCH_MARGIN = 4;

	typedef struct packed {
		rob_tag_t tag;
		reg_addr_t dest;
		logic store;
	} entry_t;

	logic clk = 1'b0;
	logic rst;
	logic issue;
	logic issue_store;
	reg_addr_t issue_dest;
	rob_tag_t issue_tag;
	logic full;
	logic wb0_valid, wb1_valid, ld0_valid, ld1_valid, st0_valid, st1_valid;
	rob_tag_t wb0_tag, wb1_tag, ld0_tag, ld1_tag, st0_tag, st1_tag;
	data_t wb0_value, wb1_value, ld0_value, ld1_value;
	logic commit0_valid, commit0_store, commit1_valid, commit1_store;
	reg_addr_t commit0_dest, commit1_dest;
	data_t commit0_value, commit1_value;
	rob_tag_t commit0_tag, commit1_tag;
	reg_addr_t src_reg;
	logic src_busy;
	rob_tag_t src_tag;
	data_t src_value;

	// reference model
	entry_t mq[$];
	logic m_ready[ROB_DEPTH];
	data_t m_value[ROB_DEPTH];
	data_t m_regs[NUM_REGS];
	logic m_busy[NUM_REGS];
	rob_tag_t m_tag[NUM_REGS];
	rob_tag_t m_tail;
	int m_count;
	// commits the DUT should be showing in the current cycle
	logic e0_valid;
	logic e1_valid;
	entry_t e0;
	entry_t e1;
	data_t e0_value;
	data_t e1_value;

	// entries issued by the stimulus and not yet completed
	entry_t pend_q[$];
	logic roam_src;
	string test_name = "reset";
	int err_count = 0;
	int test_errs = 0;
	int pass_tests = 0;
	int fail_tests = 0;
	int seed_val;

	retire_core retire_core_inst (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk or negedge rst) begin : model
		logic accept;
		if (!rst) begin
			mq.delete();
			m_tail = '0;
			m_count = 0;
			e0_valid = 1'b0;
			e1_valid = 1'b0;
			for (int i = 0; i < ROB_DEPTH; i++)
				m_ready[i] = 1'b0;
			for (int i = 0; i < NUM_REGS; i++) begin
				m_regs[i] = '0;
				m_busy[i] = 1'b0;
				m_tag[i] = '0;
			end
		end else begin
			// fullness as it stood before this edge
			accept = issue && (mq.size() < ROB_DEPTH - 1);
			// commits shown last cycle land in the register file and rename map now
			if (e0_valid && !e0.store) begin
				m_regs[e0.dest] = e0_value;
				if (m_tag[e0.dest] == e0.tag)
					m_busy[e0.dest] = 1'b0;
			end
			if (e1_valid && !e1.store) begin
				m_regs[e1.dest] = e1_value;
				if (m_tag[e1.dest] == e1.tag)
					m_busy[e1.dest] = 1'b0;
			end
			e0_valid = 1'b0;
			e1_valid = 1'b0;
			if (mq.size() > 0 && m_ready[mq[0].tag]) begin
				e0 = mq.pop_front();
				e0_value = m_value[e0.tag];
				e0_valid = 1'b1;
				if (mq.size() > 0 && m_ready[mq[0].tag]) begin
					e1 = mq.pop_front();
					e1_value = m_value[e1.tag];
					e1_valid = 1'b1;
				end
			end
			if (accept) begin
				mq.push_back('{m_tail, issue_dest, issue_store});
				m_ready[m_tail] = 1'b0;
				if (!issue_store) begin
					m_busy[issue_dest] = 1'b1;
					m_tag[issue_dest] = m_tail;
				end
				m_tail = m_tail + 1'b1;
			end
			// later ports overwrite earlier ones on a shared tag
			if (wb0_valid) begin
				m_ready[wb0_tag] = 1'b1;
				m_value[wb0_tag] = wb0_value;
			end
			if (wb1_valid) begin
				m_ready[wb1_tag] = 1'b1;
				m_value[wb1_tag] = wb1_value;
			end
			if (ld0_valid) begin
				m_ready[ld0_tag] = 1'b1;
				m_value[ld0_tag] = ld0_value;
			end
			if (ld1_valid) begin
				m_ready[ld1_tag] = 1'b1;
				m_value[ld1_tag] = ld1_value;
			end
			if (st0_valid)
				m_ready[st0_tag] = 1'b1;
			if (st1_valid)
				m_ready[st1_tag] = 1'b1;
			m_count = mq.size();
		end
	end

	task automatic report_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR %s %s expected %0h actual %0h", test_name, what, expected, actual);
		err_count++;
	endtask

	assert property (@(posedge clk) disable iff (!rst) commit0_valid == e0_valid)
		else report_value("commit0_valid", $sampled(e0_valid), $sampled(commit0_valid));
	assert property (@(posedge clk) disable iff (!rst)
		e0_valid |-> {commit0_tag, commit0_dest, commit0_store} == e0)
		else report_value("commit0 tag/dest/store", $sampled(e0),
			$sampled({commit0_tag, commit0_dest, commit0_store}));
	assert property (@(posedge clk) disable iff (!rst)
		e0_valid && !e0.store |-> commit0_value == e0_value)
		else report_value("commit0_value", $sampled(e0_value), $sampled(commit0_value));
	assert property (@(posedge clk) disable iff (!rst) commit1_valid == e1_valid)
		else report_value("commit1_valid", $sampled(e1_valid), $sampled(commit1_valid));
	assert property (@(posedge clk) disable iff (!rst)
		e1_valid |-> {commit1_tag, commit1_dest, commit1_store} == e1)
		else report_value("commit1 tag/dest/store", $sampled(e1),
			$sampled({commit1_tag, commit1_dest, commit1_store}));
	assert property (@(posedge clk) disable iff (!rst)
		e1_valid && !e1.store |-> commit1_value == e1_value)
		else report_value("commit1_value", $sampled(e1_value), $sampled(commit1_value));
	assert property (@(posedge clk) disable iff (!rst) full == (m_count == ROB_DEPTH - 1))
		else report_value("full", $sampled(m_count == ROB_DEPTH - 1), $sampled(full));
	assert property (@(posedge clk) disable iff (!rst) issue_tag == m_tail)
		else report_value("issue_tag", $sampled(m_tail), $sampled(issue_tag));
	assert property (@(posedge clk) disable iff (!rst) src_busy == m_busy[src_reg])
		else report_value("src_busy", $sampled(m_busy[src_reg]), $sampled(src_busy));
	assert property (@(posedge clk) disable iff (!rst) src_busy |-> src_tag == m_tag[src_reg])
		else report_value("src_tag", $sampled(m_tag[src_reg]), $sampled(src_tag));
	assert property (@(posedge clk) disable iff (!rst) src_value == m_regs[src_reg])
		else report_value("src_value", $sampled(m_regs[src_reg]), $sampled(src_value));

	task automatic clear_strobes();
		issue = 1'b0;
		wb0_valid = 1'b0;
		wb1_valid = 1'b0;
		ld0_valid = 1'b0;
		ld1_valid = 1'b0;
		st0_valid = 1'b0;
		st1_valid = 1'b0;
		if (roam_src)
			src_reg = reg_addr_t'($urandom);
	endtask

	// ports 0 to 5 are wb0, wb1, ld0, ld1, st0, st1
	task automatic drive_port(input int port, input rob_tag_t tag);
		case (port)
			0: begin
				wb0_valid = 1'b1;
				wb0_tag = tag;
				wb0_value = $urandom;
			end
			1: begin
				wb1_valid = 1'b1;
				wb1_tag = tag;
				wb1_value = $urandom;
			end
			2: begin
				ld0_valid = 1'b1;
				ld0_tag = tag;
				ld0_value = $urandom;
			end
			3: begin
				ld1_valid = 1'b1;
				ld1_tag = tag;
				ld1_value = $urandom;
			end
			4: begin
				st0_valid = 1'b1;
				st0_tag = tag;
			end
			default: begin
				st1_valid = 1'b1;
				st1_tag = tag;
			end
		endcase
	endtask

	task automatic issue_one(input reg_addr_t dest, input logic store);
		@(negedge clk);
		clear_strobes();
		// only an accepted issue becomes a pending entry
		if (m_count < ROB_DEPTH - 1)
			pend_q.push_back('{m_tail, dest, store});
		issue = 1'b1;
		issue_dest = dest;
		issue_store = store;
	endtask

	task automatic complete_one(input entry_t e);
		@(negedge clk);
		clear_strobes();
		if (e.store)
			drive_port(4 + $urandom_range(1, 0), e.tag);
		else
			drive_port($urandom_range(3, 0), e.tag);
	endtask

	task automatic complete_shuffled();
		entry_t tmp;
		int j;
		for (int i = pend_q.size() - 1; i > 0; i--) begin
			j = $urandom_range(i, 0);
			tmp = pend_q[i];
			pend_q[i] = pend_q[j];
			pend_q[j] = tmp;
		end
		foreach (pend_q[i])
			complete_one(pend_q[i]);
		pend_q.delete();
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			clear_strobes();
		end
	endtask

	// the extra idle cycles let the last commits reach the register file
	task automatic wait_drain();
		do
			idle(1);
		while (m_count != 0);
		idle(3);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = err_count;
	endtask

	task automatic end_test();
		if (err_count == test_errs) begin
			pass_tests++;
			$display("test %s passed", test_name);
		end else begin
			fail_tests++;
			$display("test %s failed with %0d errors", test_name, err_count - test_errs);
		end
	endtask

	initial begin
		reg_addr_t r;
		seed_val = $urandom(SEED);
		rst = 1'b0;
		roam_src = 1'b1;
		issue_dest = '0;
		issue_store = 1'b0;
		{wb0_tag, wb1_tag, ld0_tag, ld1_tag, st0_tag, st1_tag} = '0;
		{wb0_value, wb1_value, ld0_value, ld1_value} = '0;
		clear_strobes();
		repeat (2) @(negedge clk);
		rst = 1'b1;

		begin_test("reset");
		idle(3);
		end_test();

		begin_test("dual_commit");
		repeat (2) begin
			repeat (16)
				issue_one(reg_addr_t'($urandom), $urandom_range(3, 0) == 0);
			complete_shuffled();
			wait_drain();
		end
		end_test();

		begin_test("full");
		repeat (31)
			issue_one(reg_addr_t'($urandom), 1'b0);
		// dropped while full, the issuer would retry
		issue_one(reg_addr_t'($urandom), 1'b0);
		idle(2);
		complete_one(pend_q.pop_front());
		idle(3);
		issue_one(reg_addr_t'($urandom), 1'b0);
		complete_shuffled();
		wait_drain();
		end_test();

		begin_test("rename");
		roam_src = 1'b0;
		r = reg_addr_t'($urandom);
		src_reg = r;
		issue_one(r, 1'b0);
		issue_one(r, 1'b0);
		idle(1);
		// older producer retires while the newer one still owns the register
		complete_one(pend_q.pop_front());
		idle(4);
		complete_one(pend_q.pop_front());
		wait_drain();
		end_test();

		begin_test("store");
		r = reg_addr_t'($urandom);
		src_reg = r;
		issue_one(r, 1'b0);
		complete_shuffled();
		wait_drain();
		issue_one(r, 1'b1);
		issue_one(reg_addr_t'($urandom), 1'b1);
		issue_one(r, 1'b1);
		complete_shuffled();
		wait_drain();
		end_test();

		begin_test("port_priority");
		roam_src = 1'b1;
		repeat (3)
			issue_one(reg_addr_t'($urandom), 1'b0);
		@(negedge clk);
		clear_strobes();
		drive_port(0, pend_q[0].tag);
		drive_port(1, pend_q[0].tag);
		drive_port(2, pend_q[1].tag);
		drive_port(3, pend_q[1].tag);
		@(negedge clk);
		clear_strobes();
		for (int p = 0; p < 4; p++)
			drive_port(p, pend_q[2].tag);
		pend_q.delete();
		wait_drain();
		end_test();

		$display("tests passed %0d failed %0d, assertion errors %0d",
			pass_tests, fail_tests, err_count);
		if (fail_tests == 0 && err_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * WATCH_MARGIN * CLK_PERIOD);
		$display("watchdog: tests did not finish in time, the DUT or a drain loop hung");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/retire_pkg.sv
hw/reorder_buffer.sv
hw/rename_table.sv
hw/arch_regfile.sv
hw/retire_core.sv
bench/retire_core_tb.sv

// ==== hw/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import retire_pkg::*; (
	input logic clk,
	input logic rst,

	// commit slot 0
	input logic we0,
	input reg_addr_t waddr0,
	input data_t wdata0,

	// commit slot 1 holds the younger instruction
	input logic we1,
	input reg_addr_t waddr1,
	input data_t wdata1,

	// operand read
	input reg_addr_t raddr,
	output data_t rdata
);

	data_t regs [NUM_REGS];

	// committed state starts out as all zeros
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			regs <= '{default: '0};
		end else begin
			if (we0)
				regs[waddr0] <= wdata0;
			// port 1 is younger in program order, so it wins a collision
			if (we1)
				regs[waddr1] <= wdata1;
		end
	end

	// no bypass from the write ports
	assign rdata = regs[raddr];

endmodule

`default_nettype wire

// ==== hw/rename_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_table import retire_pkg::*; (
	input logic clk,
	input logic rst,

	// register-writing issue accepted this cycle
	input logic alloc,
	input reg_addr_t alloc_reg,
	input rob_tag_t alloc_tag,

	// register-writing commits
	input logic retire0,
	input reg_addr_t retire0_reg,
	input rob_tag_t retire0_tag,
	input logic retire1,
	input reg_addr_t retire1_reg,
	input rob_tag_t retire1_tag,

	// operand lookup
	input reg_addr_t src_reg,
	output logic src_busy,
	output rob_tag_t src_tag
);

	logic [NUM_REGS-1:0] busy;
	rob_tag_t tag_map [NUM_REGS];

	logic hit0;
	logic hit1;

	// a commit only frees the register if no newer producer took it over
	assign hit0 = retire0 && (tag_map[retire0_reg] == retire0_tag);
	assign hit1 = retire1 && (tag_map[retire1_reg] == retire1_tag);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= '0;
			tag_map <= '{default: '0};
		end else begin
			if (hit0)
				busy[retire0_reg] <= 1'b0;
			if (hit1)
				busy[retire1_reg] <= 1'b0;
			// allocation comes last so it overrides a same-edge retire
			if (alloc) begin
				busy[alloc_reg] <= 1'b1;
				tag_map[alloc_reg] <= alloc_tag;
			end
		end
	end

	assign src_busy = busy[src_reg];
	assign src_tag = tag_map[src_reg];

	// the buffer retires each producer once, so a live match is still busy
	assert property (@(posedge clk) disable iff (!rst)
		hit0 |-> busy[retire0_reg]);

	assert property (@(posedge clk) disable iff (!rst)
		hit1 |-> busy[retire1_reg]);

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import retire_pkg::*; (
	input logic clk,
	input logic rst,

	// issue side
	input logic issue,
	input reg_addr_t issue_dest,
	input logic issue_store,
	output rob_tag_t issue_tag,
	output logic full,
	output logic issue_accept,
	output logic alloc,

	// result bus completions
	input logic wb0_valid,
	input rob_tag_t wb0_tag,
	input data_t wb0_value,
	input logic wb1_valid,
	input rob_tag_t wb1_tag,
	input data_t wb1_value,

	// load completions
	input logic ld0_valid,
	input rob_tag_t ld0_tag,
	input data_t ld0_value,
	input logic ld1_valid,
	input rob_tag_t ld1_tag,
	input data_t ld1_value,

	// store dispatch only marks ready
	input logic st0_valid,
	input rob_tag_t st0_tag,
	input logic st1_valid,
	input rob_tag_t st1_tag,

	// registered retirement outputs
	output logic commit0_valid,
	output reg_addr_t commit0_dest,
	output data_t commit0_value,
	output logic commit0_store,
	output rob_tag_t commit0_tag,
	output logic commit0_wr,
	output logic commit1_valid,
	output reg_addr_t commit1_dest,
	output data_t commit1_value,
	output logic commit1_store,
	output rob_tag_t commit1_tag,
	output logic commit1_wr
);

	// per-slot payload
	reg_addr_t dest_mem [ROB_DEPTH];
	data_t value_mem [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] store_mem;

	logic [ROB_DEPTH-1:0] ready;
	rob_tag_t issue_ptr;
	rob_tag_t commit_ptr;

	rob_tag_t issue_next;
	rob_tag_t head_next;
	logic commit_first;
	logic commit_second;

	assign issue_next = issue_ptr + 1'b1;
	assign head_next = commit_ptr + 1'b1;

	assign issue_tag = issue_ptr;
	assign full = (issue_next == commit_ptr);
	assign issue_accept = issue && !full;

	// only register-writing issues touch the rename map
	assign alloc = issue_accept && !issue_store;

	// ready bits as they stood before this edge decide retirement
	assign commit_first = ready[commit_ptr];
	assign commit_second = commit_first && ready[head_next];

	// stores retire without a register write
	assign commit0_wr = commit0_valid && !commit0_store;
	assign commit1_wr = commit1_valid && !commit1_store;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ready <= '0;
			issue_ptr <= '0;
			commit_ptr <= '0;
			commit0_valid <= 1'b0;
			commit1_valid <= 1'b0;
		end else begin
			commit0_valid <= commit_first;
			commit1_valid <= commit_second;

			if (issue_accept) begin
				ready[issue_ptr] <= 1'b0;
				issue_ptr <= issue_next;
			end

			// completions mark their slot ready
			if (wb0_valid)
				ready[wb0_tag] <= 1'b1;
			if (wb1_valid)
				ready[wb1_tag] <= 1'b1;
			if (ld0_valid)
				ready[ld0_tag] <= 1'b1;
			if (ld1_valid)
				ready[ld1_tag] <= 1'b1;
			if (st0_valid)
				ready[st0_tag] <= 1'b1;
			if (st1_valid)
				ready[st1_tag] <= 1'b1;

			// every retired slot goes back to not ready
			if (commit_first)
				ready[commit_ptr] <= 1'b0;
			if (commit_second) begin
				ready[head_next] <= 1'b0;
				commit_ptr <= commit_ptr + 2'd2;
			end else if (commit_first) begin
				commit_ptr <= head_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue_accept) begin
			dest_mem[issue_ptr] <= issue_dest;
			store_mem[issue_ptr] <= issue_store;
		end

		// later writes win, so ld1 beats ld0 beats wb1 beats wb0
		if (wb0_valid)
			value_mem[wb0_tag] <= wb0_value;
		if (wb1_valid)
			value_mem[wb1_tag] <= wb1_value;
		if (ld0_valid)
			value_mem[ld0_tag] <= ld0_value;
		if (ld1_valid)
			value_mem[ld1_tag] <= ld1_value;

		// payload is qualified by the valid bits
		commit0_dest <= dest_mem[commit_ptr];
		commit0_value <= value_mem[commit_ptr];
		commit0_store <= store_mem[commit_ptr];
		commit0_tag <= commit_ptr;
		commit1_dest <= dest_mem[head_next];
		commit1_value <= value_mem[head_next];
		commit1_store <= store_mem[head_next];
		commit1_tag <= head_next;
	end

	// a dual commit never reaches the free slot at the tail
	assert property (@(posedge clk) disable iff (!rst)
		commit_second |-> head_next != issue_ptr);

	// the execution side must not complete the slot being handed out right now
	assert property (@(posedge clk) disable iff (!rst)
		issue_accept |-> !((wb0_valid && wb0_tag == issue_ptr) ||
			(wb1_valid && wb1_tag == issue_ptr) ||
			(ld0_valid && ld0_tag == issue_ptr) ||
			(ld1_valid && ld1_tag == issue_ptr) ||
			(st0_valid && st0_tag == issue_ptr) ||
			(st1_valid && st1_tag == issue_ptr)));

	// an empty buffer has no ready head
	assert property (@(posedge clk) disable iff (!rst)
		commit_first |-> commit_ptr != issue_ptr);

endmodule

`default_nettype wire

// ==== hw/retire_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_core import retire_pkg::*; (
	input logic clk,
	input logic rst,

	input logic issue,
	input reg_addr_t issue_dest,
	input logic issue_store,
	output rob_tag_t issue_tag,
	output logic full,

	input logic wb0_valid,
	input rob_tag_t wb0_tag,
	input data_t wb0_value,
	input logic wb1_valid,
	input rob_tag_t wb1_tag,
	input data_t wb1_value,
	input logic ld0_valid,
	input rob_tag_t ld0_tag,
	input data_t ld0_value,
	input logic ld1_valid,
	input rob_tag_t ld1_tag,
	input data_t ld1_value,
	input logic st0_valid,
	input rob_tag_t st0_tag,
	input logic st1_valid,
	input rob_tag_t st1_tag,

	output logic commit0_valid,
	output reg_addr_t commit0_dest,
	output data_t commit0_value,
	output logic commit0_store,
	output rob_tag_t commit0_tag,
	output logic commit1_valid,
	output reg_addr_t commit1_dest,
	output data_t commit1_value,
	output logic commit1_store,
	output rob_tag_t commit1_tag,

	input reg_addr_t src_reg,
	output logic src_busy,
	output rob_tag_t src_tag,
	output data_t src_value
);

	// write enables, store filtering happens inside the buffer
	logic alloc;
	logic commit0_wr;
	logic commit1_wr;

	reorder_buffer reorder_buffer_inst (
		.clk(clk), .rst(rst),
		.issue(issue), .issue_dest(issue_dest), .issue_store(issue_store),
		.issue_tag(issue_tag), .full(full), .issue_accept(), .alloc(alloc),
		.wb0_valid(wb0_valid), .wb0_tag(wb0_tag), .wb0_value(wb0_value),
		.wb1_valid(wb1_valid), .wb1_tag(wb1_tag), .wb1_value(wb1_value),
		.ld0_valid(ld0_valid), .ld0_tag(ld0_tag), .ld0_value(ld0_value),
		.ld1_valid(ld1_valid), .ld1_tag(ld1_tag), .ld1_value(ld1_value),
		.st0_valid(st0_valid), .st0_tag(st0_tag),
		.st1_valid(st1_valid), .st1_tag(st1_tag),
		.commit0_valid(commit0_valid), .commit0_dest(commit0_dest),
		.commit0_value(commit0_value), .commit0_store(commit0_store),
		.commit0_tag(commit0_tag), .commit0_wr(commit0_wr),
		.commit1_valid(commit1_valid), .commit1_dest(commit1_dest),
		.commit1_value(commit1_value), .commit1_store(commit1_store),
		.commit1_tag(commit1_tag), .commit1_wr(commit1_wr)
	);

	// the issue pointer is the tag of the new producer
	rename_table rename_table_inst (
		.clk(clk), .rst(rst),
		.alloc(alloc), .alloc_reg(issue_dest), .alloc_tag(issue_tag),
		.retire0(commit0_wr), .retire0_reg(commit0_dest), .retire0_tag(commit0_tag),
		.retire1(commit1_wr), .retire1_reg(commit1_dest), .retire1_tag(commit1_tag),
		.src_reg(src_reg), .src_busy(src_busy), .src_tag(src_tag)
	);

	arch_regfile arch_regfile_inst (
		.clk(clk), .rst(rst),
		.we0(commit0_wr), .waddr0(commit0_dest), .wdata0(commit0_value),
		.we1(commit1_wr), .waddr1(commit1_dest), .wdata1(commit1_value),
		.raddr(src_reg), .rdata(src_value)
	);

endmodule

`default_nettype wire

// ==== hw/retire_pkg.sv ====
`default_nettype none

package retire_pkg;

	// reorder buffer geometry
	// one slot always stays empty so full and empty can be told apart
	localparam int ROB_DEPTH = 32;
	localparam int TAG_W = $clog2(ROB_DEPTH);

	// architectural register space
	localparam int NUM_REGS = 32;
	localparam int REG_W = $clog2(NUM_REGS);

	// width of every result value
	localparam int DATA_W = 32;

	// slot index, doubles as the instruction tag
	typedef logic [TAG_W-1:0] rob_tag_t;

	typedef logic [REG_W-1:0] reg_addr_t;

	typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire
